/* flist.f */
verilog/lsu_isa_pkg.sv
verilog/soc_map_pkg.sv
verilog/store_align.sv
verilog/load_extract.sv
verilog/data_ram.sv
verilog/mmio_regs.sv
verilog/lsu_pipe.sv
verilog/lsu_top.sv
dv/lsu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the LSU testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module lsu_tb -Mdir obj_dir -o lsu_sim &&
./obj_dir/lsu_sim | tee /dev/stderr | grep -x "TEST PASS" > /dev/null &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}

/* dv/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

    localparam int RAM_WORDS   = 4096;
    localparam int CLK_PERIOD  = 20;
    // sample point, a quarter period before the rising edge
    localparam int SETTLE      = CLK_PERIOD / 4;
    localparam int TIMEOUT     = 50;
    localparam int ACCESS_RUNS = 5;

    localparam lsu_isa_pkg::lsu_resp_t ERR_RESP = '{rdata: 32'h0, err: 1'b1};

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_ready;
    lsu_isa_pkg::lsu_req_t  req;
    logic                   resp_valid;
    logic                   resp_ready;
    lsu_isa_pkg::lsu_resp_t resp;
    logic                   rx_valid;
    logic [7:0]             rx_data;
    logic                   rx_ready;
    logic                   tx_valid;
    logic [7:0]             tx_data;
    logic                   tx_ready;

    // receive bytes the DUT has taken
    int                     rx_taken = 0;

    lsu_top #(
        .RAM_WORDS(RAM_WORDS)
    ) lsu_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req(req),
        .resp_valid(resp_valid),
        .resp_ready(resp_ready),
        .resp(resp),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .rx_ready(rx_ready),
        .tx_valid(tx_valid),
        .tx_data(tx_data),
        .tx_ready(tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (rx_valid && rx_ready) begin
            rx_taken <= rx_taken + 1;
        end
    end

    task automatic abort_run(string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_resp(string name, lsu_isa_pkg::lsu_resp_t expected,
                              lsu_isa_pkg::lsu_resp_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s expected rdata %h err %b actual rdata %h err %b",
                                name, expected.rdata, expected.err, actual.rdata, actual.err));
        end
    endtask

    task automatic check_byte(string name, logic [7:0] expected, logic [7:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] ram_addr(int index, int offset);
        return 32'h1000_0000 + 32'(index * 4 + offset);
    endfunction

    function automatic lsu_isa_pkg::lsu_resp_t ok_resp(logic [31:0] data);
        lsu_isa_pkg::lsu_resp_t r;
        r.rdata = data;
        r.err   = 1'b0;
        return r;
    endfunction

    function automatic lsu_isa_pkg::lsu_req_t make_req(lsu_isa_pkg::lsu_op_e op,
                                                       lsu_isa_pkg::width_e w,
                                                       logic [31:0] addr, logic [31:0] data);
        lsu_isa_pkg::lsu_req_t r;
        r.op     = op;
        r.funct3 = w;
        r.addr   = addr;
        r.wdata  = data;
        return r;
    endfunction

    // memory word after a store of the given width lands at offset
    function automatic logic [31:0] merge_store(logic [31:0] old, logic [31:0] data,
                                                lsu_isa_pkg::width_e w, int offset);
        logic [31:0] result;
        int          bytes;
        result = old;
        bytes  = 1;
        if (w == lsu_isa_pkg::WIDTH_W) begin
            bytes = 4;
        end else if (w == lsu_isa_pkg::WIDTH_H || w == lsu_isa_pkg::WIDTH_HU) begin
            bytes = 2;
        end
        for (int i = 0; i < bytes; i++) begin
            result[8 * (offset + i) +: 8] = data[8 * i +: 8];
        end
        return result;
    endfunction

    // value a load should return, signed types extend on assignment
    function automatic logic [31:0] expect_load(logic [31:0] word, lsu_isa_pkg::width_e w,
                                                int offset);
        logic signed [7:0]  sbyte;
        logic signed [15:0] shalf;
        logic signed [31:0] wide;
        case (w)
            lsu_isa_pkg::WIDTH_B: begin
                sbyte = word[8 * offset +: 8];
                wide  = sbyte;
            end
            lsu_isa_pkg::WIDTH_BU: begin
                wide = {24'h0, word[8 * offset +: 8]};
            end
            lsu_isa_pkg::WIDTH_H: begin
                shalf = word[8 * offset +: 16];
                wide  = shalf;
            end
            lsu_isa_pkg::WIDTH_HU: begin
                wide = {16'h0, word[8 * offset +: 16]};
            end
            default: begin
                wide = word;
            end
        endcase
        return wide;
    endfunction

    // called on a falling edge, returns on a falling edge
    task automatic send_req(lsu_isa_pkg::lsu_req_t r);
        int   waited;
        logic taken;
        waited    = 0;
        taken     = 1'b0;
        req_valid = 1'b1;
        req       = r;
        while (!taken) begin
            if (waited == TIMEOUT) begin
                abort_run("request was never accepted");
            end
            #(SETTLE);
            taken = req_ready;
            @(negedge clk);
            waited++;
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_resp(output lsu_isa_pkg::lsu_resp_t got);
        int   waited;
        logic hit;
        waited = 0;
        hit    = 1'b0;
        while (!hit) begin
            if (waited == TIMEOUT) begin
                abort_run("no response arrived");
            end
            #(SETTLE);
            hit = resp_valid && resp_ready;
            got = resp;
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic wait_tx(logic level);
        int waited;
        waited = 0;
        while (1'b1) begin
            if (waited == TIMEOUT) begin
                abort_run("transmit valid never reached the expected level");
            end
            #(SETTLE);
            if (tx_valid == level) begin
                break;
            end
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
    endtask

    task automatic transact(input lsu_isa_pkg::lsu_req_t r,
                            output lsu_isa_pkg::lsu_resp_t got);
        send_req(r);
        wait_resp(got);
    endtask

    task automatic store_and_check(string name, lsu_isa_pkg::width_e w, logic [31:0] addr,
                                   logic [31:0] data, lsu_isa_pkg::lsu_resp_t expected);
        lsu_isa_pkg::lsu_resp_t got;
        transact(make_req(lsu_isa_pkg::LSU_STORE, w, addr, data), got);
        check_resp(name, expected, got);
    endtask

    task automatic load_and_check(string name, lsu_isa_pkg::width_e w, logic [31:0] addr,
                                  lsu_isa_pkg::lsu_resp_t expected);
        lsu_isa_pkg::lsu_resp_t got;
        transact(make_req(lsu_isa_pkg::LSU_LOAD, w, addr, 32'h0), got);
        check_resp(name, expected, got);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        #(SETTLE);
        if (resp_valid || rx_ready || tx_valid) begin
            abort_run("response valid, receive ready or transmit valid was high after reset");
        end
        @(negedge clk);
    endtask

    task automatic test_word_rw();
        int          idx  [4];
        logic [31:0] data [4];
        idx = '{0, 1, 1000, RAM_WORDS - 1};
        for (int i = 0; i < 4; i++) begin
            data[i] = $urandom();
            store_and_check("word store", lsu_isa_pkg::WIDTH_W, ram_addr(idx[i], 0), data[i],
                            ok_resp(32'h0));
        end
        for (int i = 0; i < 4; i++) begin
            load_and_check("word load", lsu_isa_pkg::WIDTH_W, ram_addr(idx[i], 0),
                           ok_resp(data[i]));
        end
    endtask

    task automatic test_sub_word();
        logic [31:0] model;
        logic [31:0] data;
        logic [31:0] patterns [2];
        model = $urandom();
        store_and_check("base store", lsu_isa_pkg::WIDTH_W, ram_addr(8, 0), model,
                        ok_resp(32'h0));
        for (int off = 0; off < 4; off++) begin
            data  = $urandom();
            model = merge_store(model, data, lsu_isa_pkg::WIDTH_B, off);
            store_and_check("byte store", lsu_isa_pkg::WIDTH_B, ram_addr(8, off), data,
                            ok_resp(32'h0));
            load_and_check("word after byte", lsu_isa_pkg::WIDTH_W, ram_addr(8, 0),
                           ok_resp(model));
        end
        for (int off = 0; off < 4; off += 2) begin
            data  = $urandom();
            model = merge_store(model, data, lsu_isa_pkg::WIDTH_H, off);
            store_and_check("half store", lsu_isa_pkg::WIDTH_H, ram_addr(8, off), data,
                            ok_resp(32'h0));
            load_and_check("word after half", lsu_isa_pkg::WIDTH_W, ram_addr(8, 0),
                           ok_resp(model));
        end
        // fixed word gives both signs for bytes and halves
        patterns[0] = model;
        patterns[1] = 32'h80ff_017f;
        for (int p = 0; p < 2; p++) begin
            store_and_check("pattern store", lsu_isa_pkg::WIDTH_W, ram_addr(8, 0), patterns[p],
                            ok_resp(32'h0));
            for (int off = 0; off < 4; off++) begin
                load_and_check("lb", lsu_isa_pkg::WIDTH_B, ram_addr(8, off),
                               ok_resp(expect_load(patterns[p], lsu_isa_pkg::WIDTH_B, off)));
                load_and_check("lbu", lsu_isa_pkg::WIDTH_BU, ram_addr(8, off),
                               ok_resp(expect_load(patterns[p], lsu_isa_pkg::WIDTH_BU, off)));
                if (off % 2 == 0) begin
                    load_and_check("lh", lsu_isa_pkg::WIDTH_H, ram_addr(8, off),
                                   ok_resp(expect_load(patterns[p], lsu_isa_pkg::WIDTH_H, off)));
                    load_and_check("lhu", lsu_isa_pkg::WIDTH_HU, ram_addr(8, off),
                                   ok_resp(expect_load(patterns[p], lsu_isa_pkg::WIDTH_HU,
                                                       off)));
                end
            end
        end
    endtask

    task automatic test_errors();
        logic [31:0] kept;
        logic [31:0] far_addr;
        kept     = $urandom();
        far_addr = ram_addr(RAM_WORDS + 24, 0);
        store_and_check("err base", lsu_isa_pkg::WIDTH_W, ram_addr(24, 0), kept, ok_resp(32'h0));
        store_and_check("sh odd", lsu_isa_pkg::WIDTH_H, ram_addr(24, 1), $urandom(), ERR_RESP);
        load_and_check("lh odd", lsu_isa_pkg::WIDTH_H, ram_addr(24, 3), ERR_RESP);
        store_and_check("sw offset", lsu_isa_pkg::WIDTH_W, ram_addr(24, 2), $urandom(), ERR_RESP);
        load_and_check("lw offset", lsu_isa_pkg::WIDTH_W, ram_addr(24, 1), ERR_RESP);
        // region 5 and the index past the end both alias word 24
        store_and_check("sw region 5", lsu_isa_pkg::WIDTH_W, 32'h5000_0000 + 32'(24 * 4),
                        $urandom(), ERR_RESP);
        load_and_check("lw region 5", lsu_isa_pkg::WIDTH_W, 32'h5000_0000 + 32'(24 * 4),
                       ERR_RESP);
        store_and_check("sw past end", lsu_isa_pkg::WIDTH_W, far_addr, $urandom(), ERR_RESP);
        load_and_check("lw past end", lsu_isa_pkg::WIDTH_W, far_addr, ERR_RESP);
        load_and_check("ram unchanged", lsu_isa_pkg::WIDTH_W, ram_addr(24, 0), ok_resp(kept));
    endtask

    task automatic test_io();
        logic [31:0] data;
        logic [7:0]  rx_byte;
        data    = $urandom();
        rx_byte = 8'($urandom());
        store_and_check("tx store", lsu_isa_pkg::WIDTH_W, soc_map_pkg::MMIO_TX_DATA, data,
                        ok_resp(32'h0));
        wait_tx(1'b1);
        check_byte("tx byte", data[7:0], tx_data);
        load_and_check("status tx full", lsu_isa_pkg::WIDTH_W, soc_map_pkg::MMIO_STATUS,
                       ok_resp(32'h0));
        tx_ready = 1'b1;
        wait_tx(1'b0);
        tx_ready = 1'b0;
        load_and_check("status tx empty", lsu_isa_pkg::WIDTH_W, soc_map_pkg::MMIO_STATUS,
                       ok_resp(32'h1));
        load_and_check("rx idle", lsu_isa_pkg::WIDTH_W, soc_map_pkg::MMIO_RX_DATA,
                       ok_resp(32'h0));
        rx_valid = 1'b1;
        rx_data  = rx_byte;
        load_and_check("status rx valid", lsu_isa_pkg::WIDTH_W, soc_map_pkg::MMIO_STATUS,
                       ok_resp(32'h3));
        load_and_check("rx byte", lsu_isa_pkg::WIDTH_W, soc_map_pkg::MMIO_RX_DATA,
                       ok_resp({24'h0, rx_byte}));
        rx_valid = 1'b0;
        // only the receive load may take the byte
        if (rx_taken != 1) begin
            abort_run($sformatf("Fail rx handshake expected 1 actual %0d", rx_taken));
        end
    endtask

    task automatic test_counters();
        lsu_isa_pkg::lsu_resp_t first;
        lsu_isa_pkg::lsu_resp_t second;
        store_and_check("counter clear", lsu_isa_pkg::WIDTH_W, soc_map_pkg::MMIO_CLEAR, 32'h0,
                        ok_resp(32'h0));
        for (int i = 0; i < ACCESS_RUNS; i++) begin
            load_and_check("counted load", lsu_isa_pkg::WIDTH_W, soc_map_pkg::MMIO_STATUS,
                           ok_resp(32'h1));
        end
        load_and_check("access count", lsu_isa_pkg::WIDTH_W, soc_map_pkg::MMIO_ACCESSES,
                       ok_resp(32'(ACCESS_RUNS + 1)));
        transact(make_req(lsu_isa_pkg::LSU_LOAD, lsu_isa_pkg::WIDTH_W,
                          soc_map_pkg::MMIO_CYCLES, 32'h0), first);
        transact(make_req(lsu_isa_pkg::LSU_LOAD, lsu_isa_pkg::WIDTH_W,
                          soc_map_pkg::MMIO_CYCLES, 32'h0), second);
        if (first.err || second.err || second.rdata <= first.rdata) begin
            abort_run("cycle counter did not advance between two reads");
        end
    endtask

    task automatic test_backpressure();
        lsu_isa_pkg::lsu_req_t  reqs [4];
        lsu_isa_pkg::lsu_resp_t exp  [4];
        lsu_isa_pkg::lsu_resp_t got;
        logic [31:0]            data;
        logic                   seen;
        for (int i = 0; i < 4; i++) begin
            data    = $urandom();
            reqs[i] = make_req(lsu_isa_pkg::LSU_LOAD, lsu_isa_pkg::WIDTH_W,
                               ram_addr(200 + i, 0), 32'h0);
            exp[i]  = ok_resp(data);
            store_and_check("queue fill", lsu_isa_pkg::WIDTH_W, ram_addr(200 + i, 0), data,
                            ok_resp(32'h0));
        end
        seen       = 1'b0;
        resp_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    send_req(reqs[i]);
                end
            end
            begin
                for (int c = 0; c < 8; c++) begin
                    #(SETTLE);
                    if (resp_valid) begin
                        seen = 1'b1;
                        if (req_ready) begin
                            abort_run("request port was ready while a response waited");
                        end
                        check_resp("held response", exp[0], resp);
                    end
                    @(negedge clk);
                end
                resp_ready = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    wait_resp(got);
                    check_resp("ordered response", exp[i], got);
                end
            end
        join
        if (!seen) begin
            abort_run("no response was held under back-pressure");
        end
        #(SETTLE);
        if (resp_valid) begin
            abort_run("an extra response appeared after the last one");
        end
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'hb2ab));
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        rx_valid   = 1'b0;
        rx_data    = 8'h00;
        tx_ready   = 1'b0;
        apply_reset();
        test_word_rw();
        test_sub_word();
        test_errors();
        test_io();
        test_counters();
        test_backpressure();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* verilog/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
    parameter int RAM_WORDS = 4096
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  lsu_isa_pkg::lsu_req_t  req,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output lsu_isa_pkg::lsu_resp_t resp,
    input  logic                   rx_valid,
    input  logic [7:0]             rx_data,
    output logic                   rx_ready,
    output logic                   tx_valid,
    output logic [7:0]             tx_data,
    input  logic                   tx_ready
);

    // store alignment
    lsu_isa_pkg::width_e            align_width;
    logic [1:0]                     align_offset;
    logic [lsu_isa_pkg::XLEN-1:0]   align_data;
    logic [3:0]                     strobe;
    logic [lsu_isa_pkg::XLEN-1:0]   aligned_data;
    logic                           misaligned;

    // data RAM
    soc_map_pkg::ram_port_t         ram;
    logic [lsu_isa_pkg::XLEN-1:0]   ram_rdata;

    // I/O page
    logic                           io_en;
    logic                           io_we;
    logic [31:0]                    io_addr;
    logic [7:0]                     io_wbyte;
    logic [31:0]                    io_rdata;
    logic                           io_err;

    // load extraction
    logic [lsu_isa_pkg::XLEN-1:0]   ext_word;
    lsu_isa_pkg::width_e            ext_width;
    logic [1:0]                     ext_offset;
    logic [lsu_isa_pkg::XLEN-1:0]   ext_data;

    lsu_pipe #(
        .RAM_WORDS(RAM_WORDS)
    ) lsu_pipe_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req(req),
        .resp_valid(resp_valid),
        .resp_ready(resp_ready),
        .resp(resp),
        .align_width(align_width),
        .align_offset(align_offset),
        .align_data(align_data),
        .strobe(strobe),
        .aligned_data(aligned_data),
        .misaligned(misaligned),
        .ram(ram),
        .ram_rdata(ram_rdata),
        .io_en(io_en),
        .io_we(io_we),
        .io_addr(io_addr),
        .io_wbyte(io_wbyte),
        .io_rdata(io_rdata),
        .io_err(io_err),
        .ext_word(ext_word),
        .ext_width(ext_width),
        .ext_offset(ext_offset),
        .ext_data(ext_data)
    );

    store_align store_align_inst (
        .width(align_width),
        .offset(align_offset),
        .data(align_data),
        .strobe(strobe),
        .aligned_data(aligned_data),
        .misaligned(misaligned)
    );

    load_extract load_extract_inst (
        .word(ext_word),
        .width(ext_width),
        .offset(ext_offset),
        .data(ext_data)
    );

    data_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) data_ram_inst (
        .clk(clk),
        .port(ram),
        .rdata(ram_rdata)
    );

    mmio_regs mmio_regs_inst (
        .clk(clk),
        .rst_n(rst_n),
        .en(io_en),
        .we(io_we),
        .addr(io_addr),
        .wbyte(io_wbyte),
        .rdata(io_rdata),
        .err(io_err),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .rx_ready(rx_ready),
        .tx_valid(tx_valid),
        .tx_data(tx_data),
        .tx_ready(tx_ready)
    );

endmodule

/* verilog/lsu_pipe.sv */
`timescale 1ns/1ps

module lsu_pipe #(
    parameter int RAM_WORDS = 4096
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  lsu_isa_pkg::lsu_req_t        req,
    output logic                         resp_valid,
    input  logic                         resp_ready,
    output lsu_isa_pkg::lsu_resp_t       resp,
    output lsu_isa_pkg::width_e          align_width,
    output logic [1:0]                   align_offset,
    output logic [lsu_isa_pkg::XLEN-1:0] align_data,
    input  logic [3:0]                   strobe,
    input  logic [lsu_isa_pkg::XLEN-1:0] aligned_data,
    input  logic                         misaligned,
    output soc_map_pkg::ram_port_t       ram,
    input  logic [lsu_isa_pkg::XLEN-1:0] ram_rdata,
    output logic                         io_en,
    output logic                         io_we,
    output logic [31:0]                  io_addr,
    output logic [7:0]                   io_wbyte,
    input  logic [31:0]                  io_rdata,
    input  logic                         io_err,
    output logic [lsu_isa_pkg::XLEN-1:0] ext_word,
    output lsu_isa_pkg::width_e          ext_width,
    output logic [1:0]                   ext_offset,
    input  logic [lsu_isa_pkg::XLEN-1:0] ext_data
);

    localparam logic [14:0] RAM_LIMIT = 15'(RAM_WORDS);

    // what the response stage needs of an accepted request
    typedef struct packed {
        lsu_isa_pkg::lsu_op_e op;
        lsu_isa_pkg::width_e  funct3;
        logic [1:0]           offset;
        logic [3:0]           region;
        logic                 err;
        logic [31:0]          io_word;
    } stage_t;

    soc_map_pkg::addr_u     req_addr;
    logic                   accept;
    logic                   is_ram;
    logic                   is_mmio;
    logic                   in_range;
    logic                   acc_err;
    logic                   s1_valid;
    stage_t                 s1;
    lsu_isa_pkg::lsu_resp_t resp_d;

    // both stages advance when the output register is empty or being drained
    assign req_ready = !resp_valid || resp_ready;
    assign accept    = req_valid && req_ready;

    // region decode
    assign req_addr = req.addr;
    assign is_ram   = req_addr.f.region == soc_map_pkg::REGION_RAM;
    assign is_mmio  = req_addr.f.region == soc_map_pkg::REGION_MMIO;
    assign in_range = {1'b0, req_addr.f.index} < RAM_LIMIT;

    assign acc_err = misaligned || !(is_ram || is_mmio) ||
                     (is_ram && !in_range) || (is_mmio && io_err);

    assign align_width  = req.funct3;
    assign align_offset = req_addr.f.offset;
    assign align_data   = req.wdata;

    always_comb begin
        ram.en     = accept && is_ram && in_range && !misaligned;
        ram.strobe = (req.op == lsu_isa_pkg::LSU_STORE) ? strobe : 4'b0000;
        ram.index  = req_addr.f.index;
        ram.wdata  = aligned_data;
    end

    // every accepted request goes to the I/O page, which counts them
    assign io_en    = accept;
    assign io_we    = req.op == lsu_isa_pkg::LSU_STORE;
    assign io_addr  = req_addr.raw;
    assign io_wbyte = req.wdata[7:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            resp_valid <= 1'b0;
        end else if (req_ready) begin
            s1_valid   <= accept;
            resp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1.op      <= req.op;
            s1.funct3  <= req.funct3;
            s1.offset  <= req_addr.f.offset;
            s1.region  <= req_addr.f.region;
            s1.err     <= acc_err;
            s1.io_word <= io_rdata;
        end
        if (req_ready && s1_valid) begin
            resp <= resp_d;
        end
    end

    // response stage, RAM word is valid here
    assign ext_word   = (s1.region == soc_map_pkg::REGION_MMIO) ? s1.io_word : ram_rdata;
    assign ext_width  = s1.funct3;
    assign ext_offset = s1.offset;

    always_comb begin
        resp_d.err   = s1.err;
        resp_d.rdata = '0;
        if (!s1.err && s1.op == lsu_isa_pkg::LSU_LOAD) begin
            resp_d.rdata = ext_data;
        end
    end

    resp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

/* verilog/mmio_regs.sv */
`timescale 1ns/1ps

module mmio_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [7:0]  wbyte,
    output logic [31:0] rdata,
    output logic        err,
    input  logic        rx_valid,
    input  logic [7:0]  rx_data,
    output logic        rx_ready,
    output logic        tx_valid,
    output logic [7:0]  tx_data,
    input  logic        tx_ready
);

    logic        hit;
    logic        tx_store;
    logic        tx_drop;
    logic        clear;
    logic [31:0] cycles;
    logic [31:0] accesses;

    assign tx_store = en && we && addr == soc_map_pkg::MMIO_TX_DATA;
    assign tx_drop  = tx_store && tx_valid;
    assign clear    = en && we && addr == soc_map_pkg::MMIO_CLEAR;

    // receive byte is taken when its load is accepted
    assign rx_ready = en && !we && addr == soc_map_pkg::MMIO_RX_DATA;

    // read mux, whole-word compare
    always_comb begin
        hit = 1'b1;
        case (addr)
            soc_map_pkg::MMIO_STATUS: begin
                rdata = {30'b0, rx_valid, !tx_valid};
            end
            soc_map_pkg::MMIO_RX_DATA: begin
                rdata = rx_valid ? {24'b0, rx_data} : 32'b0;
            end
            soc_map_pkg::MMIO_CYCLES: begin
                rdata = cycles;
            end
            soc_map_pkg::MMIO_ACCESSES: begin
                rdata = accesses;
            end
            soc_map_pkg::MMIO_TX_DATA, soc_map_pkg::MMIO_CLEAR: begin
                rdata = 32'b0;
            end
            default: begin
                rdata = 32'b0;
                hit   = 1'b0;
            end
        endcase
    end

    assign err = !hit || tx_drop;

    // transmit holding register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
        end else if (tx_store && !tx_valid) begin
            tx_valid <= 1'b1;
        end else if (tx_valid && tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_store && !tx_valid) begin
            tx_data <= wbyte;
        end
    end

    // the clear store itself is the first access counted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycles   <= 32'd0;
            accesses <= 32'd0;
        end else begin
            cycles   <= clear ? 32'd0 : cycles + 32'd1;
            accesses <= (clear ? 32'd0 : accesses) + {31'd0, en};
        end
    end

    tx_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_WORDS = 4096
) (
    input  logic                         clk,
    input  soc_map_pkg::ram_port_t       port,
    output logic [lsu_isa_pkg::XLEN-1:0] rdata
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [lsu_isa_pkg::XLEN-1:0] mem [RAM_WORDS];
    logic [AW-1:0]                word_idx;

    // the pipe only enables in-range indices
    assign word_idx = port.index[AW-1:0];

    always_ff @(posedge clk) begin
        if (port.en) begin
            for (int b = 0; b < 4; b++) begin
                if (port.strobe[b]) begin
                    mem[word_idx][8*b +: 8] <= port.wdata[8*b +: 8];
                end
            end
            // old contents on a write cycle
            rdata <= mem[word_idx];
        end
    end

endmodule

/* verilog/load_extract.sv */
`timescale 1ns/1ps

module load_extract (
    input  logic [lsu_isa_pkg::XLEN-1:0] word,
    input  lsu_isa_pkg::width_e          width,
    input  logic [1:0]                   offset,
    output logic [lsu_isa_pkg::XLEN-1:0] data
);

    logic [lsu_isa_pkg::XLEN-1:0] shifted;

    // addressed byte or half lands in the low bits
    assign shifted = word >> {offset, 3'b000};

    always_comb begin
        case (width)
            lsu_isa_pkg::WIDTH_B: begin
                data = {{24{shifted[7]}}, shifted[7:0]};
            end
            lsu_isa_pkg::WIDTH_H: begin
                data = {{16{shifted[15]}}, shifted[15:0]};
            end
            lsu_isa_pkg::WIDTH_BU: begin
                data = {24'b0, shifted[7:0]};
            end
            lsu_isa_pkg::WIDTH_HU: begin
                data = {16'b0, shifted[15:0]};
            end
            default: begin
                // whole word
                data = word;
            end
        endcase
    end

endmodule

/* verilog/store_align.sv */
`timescale 1ns/1ps

module store_align (
    input  lsu_isa_pkg::width_e          width,
    input  logic [1:0]                   offset,
    input  logic [lsu_isa_pkg::XLEN-1:0] data,
    output logic [3:0]                   strobe,
    output logic [lsu_isa_pkg::XLEN-1:0] aligned_data,
    output logic                         misaligned
);

    logic [3:0] mask;

    // lane mask at offset 0 and alignment rule per width
    always_comb begin
        mask       = 4'b0000;
        misaligned = 1'b0;
        case (width)
            lsu_isa_pkg::WIDTH_B, lsu_isa_pkg::WIDTH_BU: begin
                mask = 4'b0001;
            end
            lsu_isa_pkg::WIDTH_H, lsu_isa_pkg::WIDTH_HU: begin
                mask       = 4'b0011;
                misaligned = offset[0];
            end
            lsu_isa_pkg::WIDTH_W: begin
                mask       = 4'b1111;
                misaligned = |offset;
            end
            default: begin
                // reserved funct3, nothing legal to write
                misaligned = 1'b1;
            end
        endcase
    end

    assign strobe       = misaligned ? 4'b0000 : mask << offset;
    assign aligned_data = data << {offset, 3'b000};

    // a legal access keeps all its lanes inside the word
    always_comb begin
        assert (misaligned || ({4'b0000, mask} << offset) < 8'h10);
    end

endmodule

/* verilog/soc_map_pkg.sv */
package soc_map_pkg;

    // top address nibble of each region
    localparam logic [3:0] REGION_RAM  = 4'h1;
    localparam logic [3:0] REGION_MMIO = 4'h8;

    // I/O page registers
    localparam logic [31:0] MMIO_STATUS   = 32'h8000_0000;
    localparam logic [31:0] MMIO_RX_DATA  = 32'h8000_0004;
    localparam logic [31:0] MMIO_TX_DATA  = 32'h8000_0008;
    localparam logic [31:0] MMIO_CYCLES   = 32'h8000_0010;
    localparam logic [31:0] MMIO_ACCESSES = 32'h8000_0014;
    // a store here clears both counters
    localparam logic [31:0] MMIO_CLEAR    = 32'h8000_0018;

    // address as the RAM path splits it
    typedef struct packed {
        logic [3:0]  region;
        logic [11:0] unused;
        logic [13:0] index;
        logic [1:0]  offset;
    } addr_fields_t;

    // one address word, seen whole or in fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } addr_u;

    // one data RAM access
    // en with a zero strobe is a plain read
    typedef struct packed {
        logic        en;
        logic [3:0]  strobe;
        logic [13:0] index;
        logic [31:0] wdata;
    } ram_port_t;

endpackage

/* verilog/lsu_isa_pkg.sv */
package lsu_isa_pkg;

    // data word width seen by the core
    localparam int XLEN = 32;

    // access kind
    typedef enum logic {
        LSU_LOAD  = 1'b0,
        LSU_STORE = 1'b1
    } lsu_op_e;

    // funct3 of the load and store opcodes
    typedef enum logic [2:0] {
        WIDTH_B  = 3'b000,
        WIDTH_H  = 3'b001,
        WIDTH_W  = 3'b010,
        WIDTH_BU = 3'b100,
        WIDTH_HU = 3'b101
    } width_e;

    // one request from the execute stage
    typedef struct packed {
        lsu_op_e         op;
        width_e          funct3;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } lsu_req_t;

    // one response back to the core
    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic            err;
    } lsu_resp_t;

endpackage
